// File: verilog/dma_pkg.sv
// DMA datapath types: byte addresses, lengths and data words
// Burst request, completion metadata and the per-bank bus port structs

package dma_pkg;

  // Bytes per bank interleave region, one word
  localparam int unsigned word_bytes = 4;

  typedef logic [15:0] addr_t;
  typedef logic [15:0] len_t;
  typedef logic [31:0] word_t;

  // One copy request, byte offsets into the memory window
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_bytes;
  } burst_req_t;

  // trans_complete is a one-cycle pulse, backend_idle a level
  typedef struct packed {
    logic trans_complete;
    logic backend_idle;
  } meta_t;

  // Frontend to one bank, idx is the bank-local word index
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t idx;
    word_t wdata;
  } bank_req_t;

  // Bank to frontend, rdata arrives with rvalid one cycle after ready
  typedef struct packed {
    logic  ready;
    logic  rvalid;
    word_t rdata;
  } bank_rsp_t;

endpackage

// File: verilog/dma_axil_pkg.sv
// AXI4-Lite request and response structs for the host port
// Register offsets and the start of the memory window

package dma_axil_pkg;

  typedef logic [15:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // Master to slave channels
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // Slave to master channels, response is always OKAY
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
  } axil_rsp_t;

  // Register map
  localparam axil_addr_t reg_src  = 16'h0000;
  localparam axil_addr_t reg_dst  = 16'h0004;
  localparam axil_addr_t reg_len  = 16'h0008;
  // Write starts a copy; read gives {done count, 14'b0, error, busy}
  localparam axil_addr_t reg_ctrl = 16'h000C;

  // Scratchpad window, word w sits in bank w mod NoBanks
  localparam axil_addr_t mem_base = 16'h1000;

endpackage

// File: verilog/dma_stream_fork.sv
// Valid/ready fork from one input to NoOutputs outputs
// Sent flag per output so every output takes each item once
`timescale 1ns/1ps

module dma_stream_fork #(
  parameter int unsigned NoOutputs = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output logic [NoOutputs-1:0] valid_o,
  input  logic [NoOutputs-1:0] ready_i
);

  logic [NoOutputs-1:0] sent_q;
  logic [NoOutputs-1:0] taken;
  logic [NoOutputs-1:0] done_now;

  // Outputs that already took the item drop their valid
  assign valid_o  = {NoOutputs{valid_i}} & ~sent_q;
  assign taken    = valid_o & ready_i;
  assign done_now = sent_q | taken;

  // Upstream completes once the last outstanding output is taken
  assign ready_o = &done_now;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sent_q <= '0;
    end else if (valid_i) begin
      sent_q <= ready_o ? '0 : done_now;
    end
  end

  // After a handshake, that output stays quiet until the input item retires
  for (genvar i = 0; i < NoOutputs; i++) begin : g_once
    a_single_handshake: assert property (@(posedge clk_i) disable iff (rst_i)
      taken[i] && !(valid_i && ready_o) |=> !taken[i] until_with (valid_i && ready_o));
  end

endmodule

// File: verilog/dma_distributed_midend.sv
// Splits one burst into a request per memory bank
// Combines per-bank completion and idle metadata into one status
`timescale 1ns/1ps

module dma_distributed_midend
  import dma_pkg::*;
#(
  parameter int unsigned NoBanks = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // From the frontend
  input  burst_req_t               burst_req_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output meta_t                    meta_o,
  // To the backends
  output burst_req_t [NoBanks-1:0] burst_req_o,
  output logic       [NoBanks-1:0] valid_o,
  input  logic       [NoBanks-1:0] ready_i,
  input  meta_t      [NoBanks-1:0] meta_i
);

  logic [NoBanks-1:0] complete_q;
  logic [NoBanks-1:0] idle_q;

  // One cycle behind the banks
  assign meta_o.trans_complete = &complete_q;
  assign meta_o.backend_idle   = &idle_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      complete_q <= '0;
      idle_q     <= '1;
    end else begin
      for (int unsigned i = 0; i < NoBanks; i++) begin
        complete_q[i] <= complete_q[i] | meta_i[i].trans_complete;
        idle_q[i]     <= meta_i[i].backend_idle;
      end
      // All banks reported, start collecting the next copy
      if (meta_o.trans_complete) complete_q <= '0;
    end
  end

  dma_stream_fork #(
    .NoOutputs (NoBanks)
  ) i_stream_fork (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  // Bank i starts one word further in, each bank gets an equal share
  always_comb begin
    for (int unsigned i = 0; i < NoBanks; i++) begin
      burst_req_o[i].src       = burst_req_i.src + addr_t'(i * word_bytes);
      burst_req_o[i].dst       = burst_req_i.dst + addr_t'(i * word_bytes);
      burst_req_o[i].num_bytes = len_t'(burst_req_i.num_bytes / NoBanks);
    end
  end

  a_len_multiple: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i |-> (burst_req_i.num_bytes % (NoBanks * word_bytes)) == 0);

endmodule

// File: verilog/dma_backend.sv
// One bank of the scratchpad: word memory with synchronous read
// Copy FSM for this bank's share, bus port served only while idle
`timescale 1ns/1ps

module dma_backend
  import dma_pkg::*;
#(
  parameter int unsigned NoBanks   = 4,
  parameter int unsigned BankWords = 64
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  burst_req_t burst_req_i,
  input  logic       valid_i,
  output logic       ready_o,
  output meta_t      meta_o,
  input  bank_req_t  bank_req_i,
  output bank_rsp_t  bank_rsp_o
);

  localparam int unsigned AlignBytes = NoBanks * word_bytes;
  localparam int unsigned IdxW       = (BankWords > 1) ? $clog2(BankWords) : 1;

  typedef enum logic [1:0] {st_idle, st_read, st_write, st_done} state_e;

  state_e          state_q;
  addr_t           rd_idx_q, wr_idx_q, mem_idx;
  len_t            words_q;
  word_t           mem_q [BankWords];
  word_t           rd_data_q, mem_wdata;
  logic            mem_we, mem_re, rvalid_q;
  logic [IdxW-1:0] mem_addr;

  assign ready_o               = (state_q == st_idle);
  assign meta_o.trans_complete = (state_q == st_done);
  assign meta_o.backend_idle   = (state_q == st_idle);

  // Bus accesses stall for the whole copy
  assign bank_rsp_o.ready  = (state_q == st_idle);
  assign bank_rsp_o.rvalid = rvalid_q;
  assign bank_rsp_o.rdata  = rd_data_q;

  // Memory port mux between the bus and the copy
  always_comb begin
    mem_we    = 1'b0;
    mem_re    = 1'b0;
    mem_idx   = bank_req_i.idx;
    mem_wdata = bank_req_i.wdata;
    unique case (state_q)
      st_idle: begin
        mem_we = bank_req_i.valid && bank_req_i.write;
        mem_re = bank_req_i.valid && !bank_req_i.write;
      end
      st_read: begin
        mem_re  = 1'b1;
        mem_idx = rd_idx_q;
      end
      st_write: begin
        mem_we    = 1'b1;
        mem_idx   = wr_idx_q;
        mem_wdata = rd_data_q;
      end
      default: ;
    endcase
  end

  assign mem_addr = mem_idx[IdxW-1:0];

  always_ff @(posedge clk_i) begin
    if (mem_we) mem_q[mem_addr] <= mem_wdata;
    if (mem_re) rd_data_q <= mem_q[mem_addr];
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= st_idle;
      rvalid_q <= 1'b0;
      rd_idx_q <= '0;
      wr_idx_q <= '0;
      words_q  <= '0;
    end else begin
      rvalid_q <= (state_q == st_idle) && bank_req_i.valid && !bank_req_i.write;
      unique case (state_q)
        st_idle: begin
          if (valid_i) begin
            // Byte offset to bank-local word index
            rd_idx_q <= addr_t'(burst_req_i.src / AlignBytes);
            wr_idx_q <= addr_t'(burst_req_i.dst / AlignBytes);
            words_q  <= len_t'(burst_req_i.num_bytes / word_bytes);
            state_q  <= (burst_req_i.num_bytes == '0) ? st_done : st_read;
          end
        end
        st_read: state_q <= st_write;
        st_write: begin
          rd_idx_q <= rd_idx_q + addr_t'(1);
          wr_idx_q <= wr_idx_q + addr_t'(1);
          words_q  <= words_q - len_t'(1);
          state_q  <= (words_q == len_t'(1)) ? st_done : st_read;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Relies on the range check upstream for copies and window decode for bus accesses
  a_idx_range: assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_we || mem_re) |-> (mem_idx < BankWords));

endmodule

// File: verilog/dma_frontend.sv
// AXI4-Lite slave with src/dst/len/ctrl registers and done counter
// Request checking and launch, memory window routed to the banks
`timescale 1ns/1ps

module dma_frontend
  import dma_pkg::*;
  import dma_axil_pkg::*;
#(
  parameter int unsigned NoBanks   = 4,
  parameter int unsigned BankWords = 64
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  axil_req_t               axil_req_i,
  output axil_rsp_t               axil_rsp_o,
  output burst_req_t              burst_req_o,
  output logic                    burst_valid_o,
  input  logic                    burst_ready_i,
  input  meta_t                   meta_i,
  output bank_req_t [NoBanks-1:0] bank_req_o,
  input  bank_rsp_t [NoBanks-1:0] bank_rsp_i
);

  localparam int unsigned AlignBytes = NoBanks * word_bytes;
  localparam int unsigned WinBytes   = NoBanks * BankWords * word_bytes;
  localparam int unsigned BankSelW   = (NoBanks > 1) ? $clog2(NoBanks) : 1;

  typedef enum logic [2:0] {
    st_idle, st_mem_wr, st_mem_rd, st_mem_rdata, st_wresp, st_rresp
  } state_e;

  state_e              state_q;
  addr_t               src_q, dst_q;
  len_t                len_q;
  logic                error_q, launched_q, burst_valid_q, busy;
  logic [15:0]         done_cnt_q;
  burst_req_t          burst_req_q;
  logic [BankSelW-1:0] sel_bank_q;
  addr_t               sel_idx_q, take_off, take_word;
  axil_addr_t          take_addr;
  word_t               wdata_q, rdata_q, reg_rdata;
  logic                wr_take, rd_take, take_is_mem, ctrl_wr, req_ok;
  logic [16:0]         src_end, dst_end;

  // Writes win over reads when both are pending
  assign wr_take = (state_q == st_idle) && axil_req_i.awvalid && axil_req_i.wvalid;
  assign rd_take = (state_q == st_idle) && axil_req_i.arvalid && !wr_take;

  assign take_addr   = wr_take ? axil_req_i.awaddr : axil_req_i.araddr;
  assign take_off    = take_addr - mem_base;
  assign take_is_mem = (take_addr >= mem_base) && (take_off < WinBytes);
  assign take_word   = addr_t'(take_off / word_bytes);

  // Whole share per bank, both ranges inside the window
  assign src_end = {1'b0, src_q} + {1'b0, len_q};
  assign dst_end = {1'b0, dst_q} + {1'b0, len_q};
  assign req_ok  = (src_q % AlignBytes == 0) && (dst_q % AlignBytes == 0) &&
                   (len_q % AlignBytes == 0) && (src_end <= WinBytes) && (dst_end <= WinBytes);

  assign busy    = launched_q | ~meta_i.backend_idle;
  assign ctrl_wr = wr_take && !take_is_mem && (take_addr == reg_ctrl) && !busy;

  always_comb begin
    unique case (take_addr)
      reg_src:  reg_rdata = {16'h0, src_q};
      reg_dst:  reg_rdata = {16'h0, dst_q};
      reg_len:  reg_rdata = {16'h0, len_q};
      reg_ctrl: reg_rdata = {done_cnt_q, 14'h0, error_q, busy};
      default:  reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= st_idle;
      src_q         <= '0;
      dst_q         <= '0;
      len_q         <= '0;
      error_q       <= 1'b0;
      launched_q    <= 1'b0;
      burst_valid_q <= 1'b0;
      done_cnt_q    <= '0;
    end else begin
      if (burst_valid_q && burst_ready_i) burst_valid_q <= 1'b0;
      if (meta_i.trans_complete) begin
        launched_q <= 1'b0;
        done_cnt_q <= done_cnt_q + 16'd1;
      end
      if (ctrl_wr) begin
        // Bad request only flags, a good one clears the flag
        burst_valid_q <= req_ok;
        launched_q    <= req_ok;
        error_q       <= !req_ok;
      end
      unique case (state_q)
        st_idle: begin
          if (wr_take) begin
            state_q <= take_is_mem ? st_mem_wr : st_wresp;
            if (!take_is_mem && take_addr == reg_src) src_q <= addr_t'(axil_req_i.wdata);
            if (!take_is_mem && take_addr == reg_dst) dst_q <= addr_t'(axil_req_i.wdata);
            if (!take_is_mem && take_addr == reg_len) len_q <= len_t'(axil_req_i.wdata);
          end else if (rd_take) begin
            state_q <= take_is_mem ? st_mem_rd : st_rresp;
          end
        end
        st_mem_wr:    if (bank_rsp_i[sel_bank_q].ready) state_q <= st_wresp;
        st_mem_rd:    if (bank_rsp_i[sel_bank_q].ready) state_q <= st_mem_rdata;
        st_mem_rdata: if (bank_rsp_i[sel_bank_q].rvalid) state_q <= st_rresp;
        st_wresp:     if (axil_req_i.bready) state_q <= st_idle;
        st_rresp:     if (axil_req_i.rready) state_q <= st_idle;
        default:      state_q <= st_idle;
      endcase
    end
  end

  // Access payload and the launched request
  always_ff @(posedge clk_i) begin
    if (wr_take || rd_take) begin
      sel_bank_q <= BankSelW'(take_word % NoBanks);
      sel_idx_q  <= addr_t'(take_word / NoBanks);
      wdata_q    <= axil_req_i.wdata;
    end
    if (ctrl_wr) burst_req_q <= '{src: src_q, dst: dst_q, num_bytes: len_q};
    if (rd_take && !take_is_mem) begin
      rdata_q <= reg_rdata;
    end else if (state_q == st_mem_rdata && bank_rsp_i[sel_bank_q].rvalid) begin
      rdata_q <= bank_rsp_i[sel_bank_q].rdata;
    end
  end

  always_comb begin
    for (int unsigned b = 0; b < NoBanks; b++) begin
      bank_req_o[b].valid = (state_q == st_mem_wr || state_q == st_mem_rd) &&
                            (sel_bank_q == BankSelW'(b));
      bank_req_o[b].write = (state_q == st_mem_wr);
      bank_req_o[b].idx   = sel_idx_q;
      bank_req_o[b].wdata = wdata_q;
    end
  end

  assign burst_req_o   = burst_req_q;
  assign burst_valid_o = burst_valid_q;

  assign axil_rsp_o.awready = wr_take;
  assign axil_rsp_o.wready  = wr_take;
  assign axil_rsp_o.bvalid  = (state_q == st_wresp);
  assign axil_rsp_o.arready = rd_take;
  assign axil_rsp_o.rvalid  = (state_q == st_rresp);
  assign axil_rsp_o.rdata   = rdata_q;

  // Launched request held steady until the midend takes it
  a_burst_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    burst_valid_o && !burst_ready_i |=> burst_valid_o && $stable(burst_req_o));

endmodule

// File: verilog/dma_subsystem_top.sv
// DMA subsystem: frontend, distributed midend and one backend per bank
`timescale 1ns/1ps

module dma_subsystem_top
  import dma_pkg::*;
  import dma_axil_pkg::*;
#(
  parameter int unsigned NoBanks   = 4,
  parameter int unsigned BankWords = 64
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o
);

  burst_req_t               burst_req;
  logic                     burst_valid, burst_ready;
  meta_t                    meta;
  burst_req_t [NoBanks-1:0] bank_burst_req;
  logic       [NoBanks-1:0] bank_burst_valid, bank_burst_ready;
  meta_t      [NoBanks-1:0] bank_meta;
  bank_req_t  [NoBanks-1:0] bank_req;
  bank_rsp_t  [NoBanks-1:0] bank_rsp;

  dma_frontend #(
    .NoBanks   (NoBanks),
    .BankWords (BankWords)
  ) i_frontend (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .axil_req_i    (axil_req_i),
    .axil_rsp_o    (axil_rsp_o),
    .burst_req_o   (burst_req),
    .burst_valid_o (burst_valid),
    .burst_ready_i (burst_ready),
    .meta_i        (meta),
    .bank_req_o    (bank_req),
    .bank_rsp_i    (bank_rsp)
  );

  dma_distributed_midend #(
    .NoBanks (NoBanks)
  ) i_midend (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .burst_req_i (burst_req),
    .valid_i     (burst_valid),
    .ready_o     (burst_ready),
    .meta_o      (meta),
    .burst_req_o (bank_burst_req),
    .valid_o     (bank_burst_valid),
    .ready_i     (bank_burst_ready),
    .meta_i      (bank_meta)
  );

  for (genvar i = 0; i < NoBanks; i++) begin : g_bank
    dma_backend #(
      .NoBanks   (NoBanks),
      .BankWords (BankWords)
    ) i_backend (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .burst_req_i (bank_burst_req[i]),
      .valid_i     (bank_burst_valid[i]),
      .ready_o     (bank_burst_ready[i]),
      .meta_o      (bank_meta[i]),
      .bank_req_i  (bank_req[i]),
      .bank_rsp_o  (bank_rsp[i])
    );
  end

endmodule

// File: bench/dma_tb.sv
// Testbench for the DMA subsystem: clock, reset, LFSR and AXI4-Lite driver tasks
// Word model of the scratchpad window, register, copy and error checks, timeout
`timescale 1ns/1ps

module dma_tb
  import dma_axil_pkg::*;
();

  localparam int unsigned WinWords   = 256;
  localparam int unsigned AlignBytes = 16;
  localparam int unsigned WinUnits   = WinWords * 4 / AlignBytes;
  localparam int unsigned NumCopies  = 30;
  localparam int unsigned MaxPolls   = 100;
  // Window passes dominate, about 4 cycles per access, so 8 leaves margin
  localparam int unsigned AccessCycles = 8;
  localparam int unsigned CopyCycles   = 130;
  localparam int unsigned WinPasses    = NumCopies + 10;
  localparam int unsigned MaxCycles    = WinPasses * (WinWords * AccessCycles + CopyCycles);

  logic        clk_i;
  logic        rst_i;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic [31:0] lfsr_q;
  logic [31:0] model [WinWords];
  int unsigned error_count = 0;
  int unsigned check_count = 0;
  int unsigned cycle_count = 0;
  logic [15:0] exp_done = '0;

  dma_subsystem_top uut (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("%0d checks, %0d errors", check_count, error_count);
      $display("tests failed");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      value  = {value[30:0], fb};
    end
    return value;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("** Error: %s expected %h got %h", name, exp, act);
    end
  endtask

  // Tasks start and end 2 ns after a rising edge, ready/valid sampled at the falling edge
  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    do @(negedge clk_i); while (!(axil_rsp.awready && axil_rsp.wready));
    @(posedge clk_i);
    #2;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    do @(negedge clk_i); while (!axil_rsp.bvalid);
    @(posedge clk_i);
    #2;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    do @(negedge clk_i); while (!axil_rsp.arready);
    @(posedge clk_i);
    #2;
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    do @(negedge clk_i); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    @(posedge clk_i);
    #2;
    axil_req.rready = 1'b0;
  endtask

  task automatic wait_idle(output logic [31:0] ctrl);
    int unsigned polls;
    polls = 0;
    axil_read(reg_ctrl, ctrl);
    while (ctrl[0] && polls < MaxPolls) begin
      axil_read(reg_ctrl, ctrl);
      polls++;
    end
    if (ctrl[0]) begin
      error_count++;
      $display("Busy bit still set after %0d polls of the control register", polls);
    end
  endtask

  task automatic check_window();
    logic [31:0] data;
    for (int unsigned w = 0; w < WinWords; w++) begin
      axil_read(mem_base + 16'(w * 4), data);
      check_value($sformatf("mem[%0d]", w), model[w], data);
    end
  endtask

  task automatic apply_copy(input logic [15:0] src, input logic [15:0] dst,
                            input logic [15:0] len);
    for (int unsigned i = 0; i < len / 4; i++) begin
      model[dst / 4 + i] = model[src / 4 + i];
    end
  endtask

  // Two disjoint aligned ranges, lower one picked first, then maybe swapped
  task automatic pick_copy(output logic [15:0] src, output logic [15:0] dst,
                           output logic [15:0] len);
    int unsigned units, lo, hi;
    units = 1 + rand_bits(5) % 24;
    lo    = rand_bits(6) % (WinUnits - 2 * units + 1);
    hi    = lo + units + rand_bits(6) % (WinUnits - lo - 2 * units + 1);
    if (rand_bits(1)) begin
      src = 16'(lo * AlignBytes);
      dst = 16'(hi * AlignBytes);
    end else begin
      src = 16'(hi * AlignBytes);
      dst = 16'(lo * AlignBytes);
    end
    len = 16'(units * AlignBytes);
  endtask

  task automatic program_regs(input logic [15:0] src, input logic [15:0] dst,
                              input logic [15:0] len);
    axil_write(reg_src, {16'h0, src});
    axil_write(reg_dst, {16'h0, dst});
    axil_write(reg_len, {16'h0, len});
  endtask

  task automatic run_copy(input logic [15:0] src, input logic [15:0] dst,
                          input logic [15:0] len);
    logic [31:0] ctrl;
    program_regs(src, dst, len);
    axil_write(reg_ctrl, 32'h1);
    wait_idle(ctrl);
    exp_done = exp_done + 16'd1;
    check_value("ctrl", {exp_done, 16'h0}, ctrl);
    apply_copy(src, dst, len);
    check_window();
  endtask

  initial begin
    logic [31:0] data;
    logic [15:0] src, dst, len;
    lfsr_q   = 32'hdf24;
    axil_req = '0;
    rst_i    = 1'b1;
    repeat (5) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    // Status after reset
    axil_read(reg_ctrl, data);
    check_value("ctrl", 32'h0, data);

    // Register readback
    src = 16'(rand_bits(16));
    dst = 16'(rand_bits(16));
    len = 16'(rand_bits(16));
    program_regs(src, dst, len);
    axil_read(reg_src, data);
    check_value("src", {16'h0, src}, data);
    axil_read(reg_dst, data);
    check_value("dst", {16'h0, dst}, data);
    axil_read(reg_len, data);
    check_value("len", {16'h0, len}, data);

    // Fill the whole window, then read it back
    for (int unsigned w = 0; w < WinWords; w++) begin
      model[w] = rand_bits(32);
      axil_write(mem_base + 16'(w * 4), model[w]);
    end
    check_window();

    for (int unsigned n = 0; n < NumCopies; n++) begin
      pick_copy(src, dst, len);
      run_copy(src, dst, len);
    end

    // Misaligned source is flagged and nothing moves
    pick_copy(src, dst, len);
    program_regs(src + 16'd4, dst, len);
    axil_write(reg_ctrl, 32'h1);
    axil_read(reg_ctrl, data);
    check_value("ctrl", {exp_done, 16'h2}, data);
    check_window();
    // A good request clears the flag
    pick_copy(src, dst, len);
    run_copy(src, dst, len);

    // Zero length
    pick_copy(src, dst, len);
    run_copy(src, dst, 16'd0);

    // Second start during a long copy
    program_regs(16'h0000, 16'h0200, 16'h0180);
    axil_write(reg_ctrl, 32'h1);
    axil_write(reg_src, 32'h0000_0100);
    axil_read(reg_ctrl, data);
    check_value("ctrl.busy", 32'h1, {31'h0, data[0]});
    axil_write(reg_ctrl, 32'h1);
    wait_idle(data);
    exp_done = exp_done + 16'd1;
    check_value("ctrl", {exp_done, 16'h0}, data);
    apply_copy(16'h0000, 16'h0200, 16'h0180);
    check_window();

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
verilog/dma_pkg.sv
verilog/dma_axil_pkg.sv
verilog/dma_stream_fork.sv
verilog/dma_distributed_midend.sv
verilog/dma_backend.sv
verilog/dma_frontend.sv
verilog/dma_subsystem_top.sv
bench/dma_tb.sv
